/* accessCtrl.sv */
////////////////////////////////////////////////////////////
// Two-stage access control with a fixed latency of 2 cycles
// Stage 1 checks and issues, stage 2 forms the response
// No back-pressure, so every response must be taken
// Accesses are assumed to be naturally aligned
////////////////////////////////////////////////////////////

`include "pmaDefs.svh"

module accessCtrl import pmaPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    reqValid,
  input  logic [31:0]             reqAddr,
  input  sizeT                    reqSize,
  input  accessKindT              reqKind,
  input  logic [31:0]             reqWData,
  output logic [31:0]             chkAddr,
  output sizeT                    chkSize,
  output accessKindT              chkKind,
  input  regionSelT               regionSel,
  input  logic                    cacheable,
  input  logic                    idempotent,
  input  logic                    atomicAllowed,
  input  faultT                   fault,
  output logic                    bootEn,
  output logic                    timEn,
  output logic                    ramWe,
  output logic [3:0]              ramByteEn,
  output logic [`RAM_INDEX_W-1:0] ramIndex,
  output logic [31:0]             ramWData,
  output logic                    regEn,
  output logic                    regWe,
  output logic [1:0]              regRegion,
  output logic [1:0]              regIndex,
  input  logic [31:0]             bootRData,
  input  logic [31:0]             timRData,
  input  logic [31:0]             regRData,
  output logic                    rspValid,
  output logic [31:0]             rspRData,
  output faultT                   rspFault,
  output regionSelT               rspRegion,
  output logic                    rspCacheable,
  output logic                    rspIdempotent,
  output logic                    rspAtomicOk
);

  logic        s1Valid, issue, isWrite;
  logic [31:0] s1Addr, s1WData;
  sizeT        s1Size;
  accessKindT  s1Kind;
  logic        s2Valid, s2Store, s2Cacheable, s2Idempotent, s2AtomicOk;
  faultT       s2Fault;
  regionSelT   s2Region;

  ////////////////////////////////////////////////////////////
  // Stage 1: hold the request, check it and issue it
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) s1Valid <= 1'b0;
    else        s1Valid <= reqValid;
  end

  // Request payload is only captured on a strobe
  always_ff @(posedge clk) begin
    if (reqValid) begin
      s1Addr  <= reqAddr;
      s1Size  <= reqSize;
      s1Kind  <= reqKind;
      s1WData <= reqWData;
    end
  end

  assign chkAddr = s1Addr;
  assign chkSize = s1Size;
  assign chkKind = s1Kind;

  // A faulted access is squashed here so no store sees an enable
  assign issue   = s1Valid && (fault == faultNone);
  assign isWrite = (s1Kind == kindStore) || (s1Kind == kindAtomic);

  assign bootEn = issue && regionSel[selBootTim];
  assign timEn  = issue && regionSel[selTim];
  assign ramWe  = issue && isWrite;
  assign regEn  = issue && |regionSel[selClint:selPlic];
  assign regWe  = issue && isWrite;

  // Word index inside each store
  assign ramIndex = s1Addr[`RAM_INDEX_W+1:2];
  assign regIndex = s1Addr[3:2];

  // CLINT, GPIO, UART and PLIC map to banks 0 to 3
  assign regRegion = {regionSel[selUart] | regionSel[selPlic],
                      regionSel[selGpio] | regionSel[selPlic]};

  // Lanes follow the size and low address bits, and the data is replicated
  // so that every enabled lane sees the right bytes
  always_comb begin
    case (s1Size)
      sizeByte: begin
        ramByteEn = 4'b0001 << s1Addr[1:0];
        ramWData  = {4{s1WData[7:0]}};
      end
      sizeHalf: begin
        ramByteEn = 4'b0011 << {s1Addr[1], 1'b0};
        ramWData  = {2{s1WData[15:0]}};
      end
      default: begin
        ramByteEn = 4'b1111;
        ramWData  = s1WData;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s2Valid      <= 1'b0;
      s2Store      <= 1'b0;
      s2Fault      <= faultNone;
      s2Region     <= '0;
      s2Cacheable  <= 1'b0;
      s2Idempotent <= 1'b0;
      s2AtomicOk   <= 1'b0;
    end else begin
      s2Valid      <= s1Valid;
      s2Store      <= (s1Kind == kindStore);
      s2Fault      <= fault;
      s2Region     <= regionSel;
      s2Cacheable  <= cacheable;
      s2Idempotent <= idempotent;
      s2AtomicOk   <= atomicAllowed;
    end
  end

  // Store read data lands in the same cycle as the stage 2 registers
  always_comb begin
    rspRData = '0;
    if ((s2Fault == faultNone) && !s2Store) begin
      if (s2Region[selBootTim])  rspRData = bootRData;
      else if (s2Region[selTim]) rspRData = timRData;
      else                       rspRData = regRData;
    end
  end

  assign rspValid      = s2Valid;
  assign rspFault      = s2Fault;
  assign rspRegion     = s2Region;
  assign rspCacheable  = s2Cacheable;
  assign rspIdempotent = s2Idempotent;
  assign rspAtomicOk   = s2AtomicOk;

endmodule

/* memSubsys.f */
+incdir+.
pmaPkg.sv
pmaChecker.sv
accessCtrl.sv
timRam.sv
periphRegs.sv
memSubsys.sv
memSubsysTb.sv

/* memSubsys.sv */
////////////////////////////////////////////////////////////
// Memory subsystem top level
// One request strobe per cycle at most, responses 2 cycles later
// The caller must accept every response
////////////////////////////////////////////////////////////

`include "pmaDefs.svh"

module memSubsys import pmaPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic        reqValid,
  input  logic [31:0] reqAddr,
  input  sizeT        reqSize,
  input  accessKindT  reqKind,
  input  logic [31:0] reqWData,
  output logic        rspValid,
  output logic [31:0] rspRData,
  output faultT       rspFault,
  output regionSelT   rspRegion,
  output logic        rspCacheable,
  output logic        rspIdempotent,
  output logic        rspAtomicOk
);

  // Checker interface
  logic [31:0]             chkAddr;
  sizeT                    chkSize;
  accessKindT              chkKind;
  regionSelT               regionSel;
  logic                    cacheable, idempotent, atomicAllowed;
  faultT                   fault;

  // Store interface whose lanes and data are shared by all stores
  logic                    bootEn, timEn, ramWe, regEn, regWe;
  logic [3:0]              ramByteEn;
  logic [`RAM_INDEX_W-1:0] ramIndex;
  logic [31:0]             ramWData;
  logic [1:0]              regRegion, regIndex;
  logic [31:0]             bootRData, timRData, regRData;

  pmaChecker pmaCheck (
    .addr(chkAddr), .size(chkSize), .kind(chkKind), .regionSel(regionSel),
    .cacheable(cacheable), .idempotent(idempotent), .atomicAllowed(atomicAllowed),
    .fault(fault)
  );

  accessCtrl ctrl (
    .clk(clk), .arstN(arstN), .reqValid(reqValid), .reqAddr(reqAddr),
    .reqSize(reqSize), .reqKind(reqKind), .reqWData(reqWData),
    .chkAddr(chkAddr), .chkSize(chkSize), .chkKind(chkKind),
    .regionSel(regionSel), .cacheable(cacheable), .idempotent(idempotent),
    .atomicAllowed(atomicAllowed), .fault(fault),
    .bootEn(bootEn), .timEn(timEn), .ramWe(ramWe), .ramByteEn(ramByteEn),
    .ramIndex(ramIndex), .ramWData(ramWData), .regEn(regEn), .regWe(regWe),
    .regRegion(regRegion), .regIndex(regIndex),
    .bootRData(bootRData), .timRData(timRData), .regRData(regRData),
    .rspValid(rspValid), .rspRData(rspRData), .rspFault(rspFault),
    .rspRegion(rspRegion), .rspCacheable(rspCacheable),
    .rspIdempotent(rspIdempotent), .rspAtomicOk(rspAtomicOk)
  );

  // Boot TIM only needs the low bits of the shared index
  timRam #(.WORDS(`BOOTTIM_WORDS)) bootTim (
    .clk(clk), .en(bootEn), .we(ramWe), .byteEn(ramByteEn),
    .index(ramIndex[$clog2(`BOOTTIM_WORDS)-1:0]), .wData(ramWData), .rData(bootRData)
  );

  timRam #(.WORDS(`TIM_WORDS)) tim (
    .clk(clk), .en(timEn), .we(ramWe), .byteEn(ramByteEn),
    .index(ramIndex), .wData(ramWData), .rData(timRData)
  );

  periphRegs periph (
    .clk(clk), .arstN(arstN), .en(regEn), .we(regWe), .byteEn(ramByteEn),
    .region(regRegion), .index(regIndex), .wData(ramWData), .rData(regRData)
  );

endmodule

/* memSubsysTb.sv */
////////////////////////////////////////////////////////////
// Self-checking testbench for the memory subsystem
// Cases come from pmaCases.txt in the project root
// Requests go out in pairs, back to back, with random gaps between pairs
// RAM words are not reset, so a case must write a word before reading it
////////////////////////////////////////////////////////////

module memSubsysTb import pmaPkg::*; ();

  localparam int clkPeriod   = 10;
  localparam int resetCycles = 8;
  localparam int rspLatency  = 2;

  logic        clk;
  logic        arstN;
  logic        reqValid;
  logic [31:0] reqAddr;
  sizeT        reqSize;
  accessKindT  reqKind;
  logic [31:0] reqWData;
  logic        rspValid;
  logic [31:0] rspRData;
  faultT       rspFault;
  regionSelT   rspRegion;
  logic        rspCacheable, rspIdempotent, rspAtomicOk;

  // Case table, one entry per line of the case file
  string       caseName[$];
  accessKindT  caseKind[$];
  sizeT        caseSize[$];
  logic [31:0] caseAddr[$];
  logic [31:0] caseWData[$];
  logic [31:0] caseRData[$];
  faultT       caseFault[$];
  regionSelT   caseRegion[$];
  // Flags are packed as cacheable, idempotent, atomicOk from the top
  logic [2:0]  caseFlags[$];
  int          numCases = 0;

  // Requests in flight, oldest first, with the edge that took each strobe
  int          pendIdx[$];
  int          pendEdge[$];
  int          cycleCount = 0;
  int          rspCount = 0;
  int unsigned lcgState = 33578;

  memSubsys UUT (
    .clk(clk), .arstN(arstN), .reqValid(reqValid), .reqAddr(reqAddr),
    .reqSize(reqSize), .reqKind(reqKind), .reqWData(reqWData),
    .rspValid(rspValid), .rspRData(rspRData), .rspFault(rspFault),
    .rspRegion(rspRegion), .rspCacheable(rspCacheable),
    .rspIdempotent(rspIdempotent), .rspAtomicOk(rspAtomicOk)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Counts rising edges, read only away from the edge
  always @(posedge clk) cycleCount <= cycleCount + 1;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic failRun(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic checkFault(input string name, input faultT exp, input faultT act);
    if (act !== exp)
      failRun($sformatf("Error: %s fault expected %0d actual %0d", name, exp, act));
  endtask

  task automatic checkRegion(input string name, input regionSelT exp, input regionSelT act);
    if (act !== exp)
      failRun($sformatf("Error: %s region expected %b actual %b", name, exp, act));
  endtask

  task automatic checkData(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      failRun($sformatf("Error: %s read data expected %h actual %h", name, exp, act));
  endtask

  task automatic checkFlag(input string name, input string flag, input logic exp,
                           input logic act);
    if (act !== exp)
      failRun($sformatf("Error: %s %s expected %b actual %b", name, flag, exp, act));
  endtask

  // Plain LCG, the upper half is the better-mixed part
  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  task automatic loadCases();
    int          fd, n, kindV, sizeV, faultV, cV, iV, aV;
    string       line, nameV;
    logic [31:0] addrV, wDataV, rDataV, regionV;
    fd = $fopen("pmaCases.txt", "r");
    if (fd == 0) failRun("Could not open the case file pmaCases.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Comment lines start with a hash, blank lines scan to nothing
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %d %d %h %h %d %h %h %d %d %d", nameV, kindV, sizeV,
                    addrV, wDataV, faultV, regionV, rDataV, cV, iV, aV);
        if (n == 11) begin
          caseName.push_back(nameV);
          caseKind.push_back(accessKindT'(kindV[1:0]));
          caseSize.push_back(sizeT'(sizeV[1:0]));
          caseAddr.push_back(addrV);
          caseWData.push_back(wDataV);
          caseFault.push_back(faultT'(faultV[1:0]));
          caseRegion.push_back(regionSelT'(regionV[5:0]));
          caseRData.push_back(rDataV);
          caseFlags.push_back({cV[0], iV[0], aV[0]});
        end else if (n > 0) begin
          failRun({"Malformed line in the case file: ", line});
        end
      end
    end
    $fclose(fd);
    numCases = caseName.size();
  endtask

  // Drives one request just after the edge, it is taken at the next one
  task automatic driveCase(input int i);
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    reqAddr  = caseAddr[i];
    reqSize  = caseSize[i];
    reqKind  = caseKind[i];
    reqWData = caseWData[i];
    pendIdx.push_back(i);
    pendEdge.push_back(cycleCount + 1);
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  // The response seen at a falling edge is taken by the outside at the next rising edge
  task automatic checkResponse(input int i, input int strobeEdge);
    string name;
    name = caseName[i];
    if (cycleCount + 1 != strobeEdge + rspLatency)
      failRun($sformatf("Error: %s response edge expected %0d actual %0d", name,
                        strobeEdge + rspLatency, cycleCount + 1));
    checkFault(name, caseFault[i], rspFault);
    checkRegion(name, caseRegion[i], rspRegion);
    checkData(name, caseRData[i], rspRData);
    checkFlag(name, "cacheable", caseFlags[i][2], rspCacheable);
    checkFlag(name, "idempotent", caseFlags[i][1], rspIdempotent);
    checkFlag(name, "atomicOk", caseFlags[i][0], rspAtomicOk);
  endtask

  ////////////////////////////////////////////////////////////
  // Response monitor and watchdog
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (arstN && rspValid) begin
      if (pendIdx.size() == 0) begin
        failRun("A response arrived while no request was in flight");
      end else begin
        checkResponse(pendIdx.pop_front(), pendEdge.pop_front());
        rspCount = rspCount + 1;
      end
    end
  end

  // Budget is 20 cycles per case on top of the reset time
  initial begin
    wait (numCases > 0);
    #((resetCycles + 20 * numCases) * clkPeriod);
    failRun("Timeout: responses stopped arriving before every case was answered");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int gap;
    arstN    = 1'b0;
    reqValid = 1'b0;
    reqAddr  = '0;
    reqSize  = sizeWord;
    reqKind  = kindLoad;
    reqWData = '0;
    loadCases();
    if (numCases == 0) failRun("The case file holds no cases");
    repeat (resetCycles) @(posedge clk);
    #1;
    arstN = 1'b1;
    for (int i = 0; i < numCases; i++) begin
      driveCase(i);
      // Each pair stays back to back so a store and its load overlap in the pipe
      if (i % 2 == 1) begin
        gap = nextRand() % 4;
        repeat (gap) idleCycle();
      end
    end
    idleCycle();
    while (rspCount < numCases) @(posedge clk);
    // A few more cycles so that a stray extra response gets caught
    repeat (4) @(posedge clk);
    if (rspCount != numCases) begin
      failRun($sformatf("Response count %0d does not match request count %0d",
                        rspCount, numCases));
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

/* periphRegs.sv */
////////////////////////////////////////////////////////////
// Scratch registers in place of CLINT, GPIO, UART and PLIC
// Four words per bank, all cleared by reset
// Reads before it writes, like the RAMs
////////////////////////////////////////////////////////////

module periphRegs (
  input  logic        clk,
  input  logic        arstN,
  input  logic        en,
  input  logic        we,
  input  logic [3:0]  byteEn,
  input  logic [1:0]  region,
  input  logic [1:0]  index,
  input  logic [31:0] wData,
  output logic [31:0] rData
);

  // Bank 0 is CLINT, then GPIO, UART and PLIC
  logic [31:0] regs [4][4];

  ////////////////////////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rData <= '0;
      for (int b = 0; b < 4; b++) begin
        for (int w = 0; w < 4; w++) begin
          regs[b][w] <= '0;
        end
      end
    end else if (en) begin
      // Old word goes out even on a write
      rData <= regs[region][index];
      if (we) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (byteEn[lane]) begin
            regs[region][index][8*lane +: 8] <= wData[8*lane +: 8];
          end
        end
      end
    end
  end

endmodule

/* pmaCases.txt */
# name kind(0 fetch 1 load 2 store 3 atomic) size(0 byte 1 half 2 word) addr wdata
# fault(0 none 1 instr 2 load 3 store) region(hex one-hot) rdata cacheable idempotent atomicOk
st_boot     2 2 00001010 11223344 0 20 00000000 1 1 1
ld_boot     1 2 00001010 00000000 0 20 11223344 1 1 1
st_tim      2 2 80000100 a5a5a5a5 0 10 00000000 1 1 1
ld_tim      1 2 80000100 00000000 0 10 a5a5a5a5 1 1 1
ld_clint    1 2 02000004 00000000 0 08 00000000 0 0 0
ld_gpio     1 2 10012008 00000000 0 04 00000000 0 0 0
ld_uart     1 0 10000000 00000000 0 02 00000000 0 0 0
ld_plic     1 2 0c00000c 00000000 0 01 00000000 0 0 0
fetch_boot  0 2 00001010 00000000 0 20 11223344 1 1 1
fetch_empty 0 2 00003000 00000000 1 00 00000000 0 0 0
ld_empty    1 2 80004000 00000000 2 00 00000000 0 0 0
st_empty    2 2 80004100 deadbeef 3 00 00000000 0 0 0
at_empty    3 2 80004100 12345678 3 00 00000000 0 0 0
ld_tim_kept 1 2 80000100 00000000 0 10 a5a5a5a5 1 1 1
st_tim_w    2 2 80000200 00000000 0 10 00000000 1 1 1
st_tim_b    2 0 80000201 000000ab 0 10 00000000 1 1 1
st_tim_h    2 1 80000202 0000cdef 0 10 00000000 1 1 1
ld_tim_m    1 2 80000200 00000000 0 10 cdefab00 1 1 1
st_gpio_b   2 0 10012003 00000077 0 04 00000000 0 0 0
st_gpio_h   2 1 10012000 00001234 0 04 00000000 0 0 0
ld_gpio_m   1 2 10012000 00000000 0 04 77001234 0 0 0
at_tim      3 2 80000200 55aa55aa 0 10 cdefab00 1 1 1
ld_tim_at   1 2 80000200 00000000 0 10 55aa55aa 1 1 1
at_gpio     3 2 10012000 ffffffff 3 04 00000000 0 0 0
ld_gpio_at  1 2 10012000 00000000 0 04 77001234 0 0 0
st_uart_b   2 0 10000004 0000005a 0 02 00000000 0 0 0
st_uart_w   2 2 10000004 12345678 3 00 00000000 0 0 0
ld_uart_b   1 0 10000004 00000000 0 02 0000005a 0 0 0
st_tim_p    2 2 80000300 0badf00d 0 10 00000000 1 1 1
ld_tim_p    1 2 80000300 00000000 0 10 0badf00d 1 1 1

/* pmaChecker.sv */
////////////////////////////////////////////////////////////
// Combinational physical memory attribute check
// Only the two RAM regions are cacheable, idempotent and
// atomic-capable, and UART only decodes for byte accesses
// Every access fault of the subsystem is raised here
////////////////////////////////////////////////////////////

`include "pmaDefs.svh"

module pmaChecker import pmaPkg::*; (
  input  logic [31:0] addr,
  input  sizeT        size,
  input  accessKindT  kind,
  output regionSelT   regionSel,
  output logic        cacheable,
  output logic        idempotent,
  output logic        atomicAllowed,
  output faultT       fault
);

  logic hitBootTim, hitTim, hitClint, hitGpio, hitUart, hitPlic;
  logic preHitUart;
  logic empty;

  // An address hits when every bit above the range mask equals the base
  function automatic logic regionHit(input logic [31:0] a, input logic [31:0] base,
                                     input logic [31:0] range);
    return (a & ~range) == base;
  endfunction

  ////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////

  assign hitBootTim = regionHit(addr, `BOOTTIM_BASE, `BOOTTIM_RANGE);
  assign hitTim     = regionHit(addr, `TIM_BASE, `TIM_RANGE);
  assign hitClint   = regionHit(addr, `CLINT_BASE, `CLINT_RANGE);
  assign hitGpio    = regionHit(addr, `GPIO_BASE, `GPIO_RANGE);
  assign preHitUart = regionHit(addr, `UART_BASE, `UART_RANGE);
  assign hitPlic    = regionHit(addr, `PLIC_BASE, `PLIC_RANGE);

  // The UART window is byte-wide, so wider accesses fall through to empty
  assign hitUart = preHitUart && (size == sizeByte);

  // Bit order matches the selT positions in the package
  assign regionSel = {hitBootTim, hitTim, hitClint, hitGpio, hitUart, hitPlic};
  assign empty     = ~|regionSel;

  ////////////////////////////////////////////////////////////
  // Attributes
  ////////////////////////////////////////////////////////////

  // The RAMs are the only well-behaved memory in the map
  assign cacheable     = hitBootTim | hitTim;
  assign idempotent    = hitBootTim | hitTim;
  assign atomicAllowed = hitBootTim | hitTim;

  ////////////////////////////////////////////////////////////
  // Fault generation
  ////////////////////////////////////////////////////////////

  always_comb begin
    fault = faultNone;
    case (kind)
      kindFetch:  if (empty) fault = faultInstr;
      kindLoad:   if (empty) fault = faultLoad;
      kindStore:  if (empty) fault = faultStore;
      // An empty region is never atomic-capable, so one test covers both cases
      kindAtomic: if (!atomicAllowed) fault = faultStore;
      default:    fault = faultNone;
    endcase
  end

endmodule

/* pmaDefs.svh */
////////////////////////////////////////////////////////////
// Physical memory map of the subsystem
// A range is a mask of low one-bits and a base must be aligned to it
// Each peripheral window holds four 32-bit words
// TIM must stay the larger RAM because the shared RAM index is sized for it
////////////////////////////////////////////////////////////

`ifndef PMA_DEFS_SVH
`define PMA_DEFS_SVH

////////////////////////////////////////////////////////////
// Region bases and ranges
////////////////////////////////////////////////////////////

// Boot TIM holds 4 KiB
`define BOOTTIM_BASE  32'h0000_1000
`define BOOTTIM_RANGE 32'h0000_0FFF

// Main TIM holds 16 KiB
`define TIM_BASE      32'h8000_0000
`define TIM_RANGE     32'h0000_3FFF

// Peripheral windows are 16 bytes each
`define CLINT_BASE    32'h0200_0000
`define CLINT_RANGE   32'h0000_000F
`define GPIO_BASE     32'h1001_2000
`define GPIO_RANGE    32'h0000_000F
`define UART_BASE     32'h1000_0000
`define UART_RANGE    32'h0000_000F
`define PLIC_BASE     32'h0C00_0000
`define PLIC_RANGE    32'h0000_000F

////////////////////////////////////////////////////////////
// RAM depths
////////////////////////////////////////////////////////////

// Word counts follow directly from the byte ranges
`define BOOTTIM_WORDS ((`BOOTTIM_RANGE + 1) / 4)
`define TIM_WORDS     ((`TIM_RANGE + 1) / 4)

// Width of the word index shared by both RAMs
`define RAM_INDEX_W   $clog2(`TIM_WORDS)

`endif

/* pmaPkg.sv */
////////////////////////////////////////////////////////////
// Types shared by the memory subsystem
// Size encoding 2'b11 is not named and is handled as a word
////////////////////////////////////////////////////////////

package pmaPkg;

  // Kind of access carried with each request
  typedef enum logic [1:0] {
    kindFetch  = 2'd0,
    kindLoad   = 2'd1,
    kindStore  = 2'd2,
    kindAtomic = 2'd3
  } accessKindT;

  // Fault code returned with each response
  typedef enum logic [1:0] {
    faultNone  = 2'd0,
    faultInstr = 2'd1,
    faultLoad  = 2'd2,
    faultStore = 2'd3
  } faultT;

  // Access size in bytes as a power of two
  typedef enum logic [1:0] {
    sizeByte = 2'd0,
    sizeHalf = 2'd1,
    sizeWord = 2'd2
  } sizeT;

  // One-hot region select, all zero when no region is hit
  typedef logic [5:0] regionSelT;

  // Bit positions inside regionSelT
  localparam int unsigned selBootTim = 5;
  localparam int unsigned selTim     = 4;
  localparam int unsigned selClint   = 3;
  localparam int unsigned selGpio    = 2;
  localparam int unsigned selUart    = 1;
  localparam int unsigned selPlic    = 0;

endpackage

/* timRam.sv */
////////////////////////////////////////////////////////////
// Synchronous word RAM with byte-lane writes
// Reads before it writes, so a swap returns the old word
// Contents are not reset and must be written before use
////////////////////////////////////////////////////////////

module timRam #(
  parameter int WORDS = 1024
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [3:0]               byteEn,
  input  logic [$clog2(WORDS)-1:0] index,
  input  logic [31:0]              wData,
  output logic [31:0]              rData
);

  logic [31:0] mem [WORDS];

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // Read data holds its value while the RAM is idle
  always_ff @(posedge clk) begin
    if (en) begin
      rData <= mem[index];
    end
  end

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // The nonblocking write means the read above sees the old word
  always_ff @(posedge clk) begin
    if (en && we) begin
      for (int lane = 0; lane < 4; lane++) begin
        // Only the lanes named by byteEn change
        if (byteEn[lane]) begin
          mem[index][8*lane +: 8] <= wData[8*lane +: 8];
        end
      end
    end
  end

endmodule
